//--- src/uart_line_pkg.sv
//////////////////////////////////////////////////
// serial line side: character, divisor and counter types
// 16x oversampling, fixed 16-entry FIFOs
//////////////////////////////////////////////////
package uart_line_pkg;

	localparam int OVERSAMPLE = 16; // ticks per bit
	localparam int MID_SAMPLE = 7;  // sampling phase inside a bit
	localparam int FIFO_DEPTH = 16;
	localparam int FIFO_AW    = 4;
	localparam int RX_ENTRY_W = 10;

	// rx entry layout: data in 7:0, then the two error flags
	localparam int RX_PE_BIT = 8;
	localparam int RX_FE_BIT = 9;

	typedef logic [7:0]            data_t;     // one character
	typedef logic [15:0]           divisor_t;  // baud divisor
	typedef logic [2:0]            bit_cnt_t;  // data bit index
	typedef logic [3:0]            tick_cnt_t; // oversampling phase
	typedef logic [RX_ENTRY_W-1:0] rx_entry_t; // {fe, pe, data}

endpackage

//--- src/uart_regs_pkg.sv
//////////////////////////////////////////////////
// host register map, 16550 layout without modem regs
// addresses 4 and 6 read zero
//////////////////////////////////////////////////
package uart_regs_pkg;

	typedef logic [2:0] reg_addr_t;
	typedef logic [3:0] iir_code_t;

	///////////////// addresses //////////////////////
	localparam reg_addr_t ADDR_RBR_THR_DLL = 3'd0;
	localparam reg_addr_t ADDR_IER_DLM     = 3'd1;
	localparam reg_addr_t ADDR_IIR_FCR     = 3'd2;
	localparam reg_addr_t ADDR_LCR         = 3'd3;
	localparam reg_addr_t ADDR_LSR         = 3'd5;
	localparam reg_addr_t ADDR_SCR         = 3'd7;

	///////////////// bit positions //////////////////
	localparam int LCR_WLS  = 0; // low bit of 2-bit field, length - 5
	localparam int LCR_PEN  = 3;
	localparam int LCR_EPS  = 4;
	localparam int LCR_DLAB = 7;

	localparam int IER_RDA  = 0;
	localparam int IER_THRE = 1;
	localparam int IER_RLS  = 2;

	localparam int FCR_RX_CLR = 1;
	localparam int FCR_TX_CLR = 2;

	localparam int LSR_DR      = 0;
	localparam int LSR_OE      = 1;
	localparam int LSR_PE      = 2;
	localparam int LSR_FE      = 3;
	localparam int LSR_THRE    = 5;
	localparam int LSR_TEMT    = 6;
	localparam int LSR_FIFOERR = 7;

	// IIR low nibble, bit 0 set means nothing pending
	localparam iir_code_t IIR_NONE = 4'h1;
	localparam iir_code_t IIR_RLS  = 4'h6;
	localparam iir_code_t IIR_RDA  = 4'h4;
	localparam iir_code_t IIR_THRE = 4'h2;
	localparam logic [3:0] IIR_FIFO_BITS = 4'hC; // FIFOs always on

endpackage

//--- src/uart_regs.sv
`timescale 1ns/1ns
//////////////////////////////////////////////////
// bus decode, config regs, LSR and interrupt priority
// read side effects happen at the edge of the cs cycle
//////////////////////////////////////////////////
module uart_regs (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     cs,
	input  logic                     wr,
	input  uart_regs_pkg::reg_addr_t addr,
	input  uart_line_pkg::data_t     wdata,
	input  logic                     tx_empty,
	input  logic                     tx_busy,
	input  logic                     rx_empty,
	input  logic                     rx_full,
	input  logic                     rx_push,
	input  uart_line_pkg::rx_entry_t rx_head,
	output uart_line_pkg::data_t     rdata,
	output logic                     irq,
	output logic                     tx_push,
	output logic                     rx_pop,
	output logic                     tx_clr,
	output logic                     rx_clr,
	output uart_line_pkg::divisor_t  divisor,
	output logic [1:0]               wls,
	output logic                     pen,
	output logic                     eps
);
	logic [2:0]               ier;
	uart_line_pkg::data_t     lcr;
	uart_line_pkg::data_t     scr;
	uart_line_pkg::data_t     dll;
	uart_line_pkg::data_t     dlm;
	uart_line_pkg::data_t     lsr;
	uart_regs_pkg::iir_code_t iir_code;
	logic                     wr_en;
	logic                     rd_en;
	logic                     dlab;
	logic                     ier_wr;
	logic                     lsr_rd;
	logic                     iir_rd;
	logic                     oe;
	logic                     pe;
	logic                     fe;
	logic                     head_checked; // current rx head already looked at
	logic                     head_new;
	logic                     tx_empty_q;
	logic                     thre_int;

	////////////////// decode ////////////////////////
	assign wr_en   = cs & wr;
	assign rd_en   = cs & ~wr;
	assign dlab    = lcr[uart_regs_pkg::LCR_DLAB];
	assign tx_push = wr_en && addr == uart_regs_pkg::ADDR_RBR_THR_DLL && !dlab;
	assign rx_pop  = rd_en && addr == uart_regs_pkg::ADDR_RBR_THR_DLL && !dlab;
	assign ier_wr  = wr_en && addr == uart_regs_pkg::ADDR_IER_DLM && !dlab;
	assign tx_clr  = wr_en && addr == uart_regs_pkg::ADDR_IIR_FCR
	                 && wdata[uart_regs_pkg::FCR_TX_CLR];
	assign rx_clr  = wr_en && addr == uart_regs_pkg::ADDR_IIR_FCR
	                 && wdata[uart_regs_pkg::FCR_RX_CLR];
	assign lsr_rd  = rd_en && addr == uart_regs_pkg::ADDR_LSR;
	assign iir_rd  = rd_en && addr == uart_regs_pkg::ADDR_IIR_FCR;

	assign divisor = {dlm, dll};
	assign wls     = lcr[uart_regs_pkg::LCR_WLS +: 2];
	assign pen     = lcr[uart_regs_pkg::LCR_PEN];
	assign eps     = lcr[uart_regs_pkg::LCR_EPS]; // 1 = even

	always_ff @(posedge clk) begin
		if (rst) begin
			ier <= '0;
			lcr <= '0;
			dll <= '0;
			dlm <= '0;
		end else if (wr_en) begin
			case (addr)
				uart_regs_pkg::ADDR_RBR_THR_DLL: begin
					if (dlab)
						dll <= wdata;
				end
				uart_regs_pkg::ADDR_IER_DLM: begin
					if (dlab)
						dlm <= wdata;
					else
						ier <= wdata[2:0];
				end
				uart_regs_pkg::ADDR_LCR: lcr <= wdata;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en && addr == uart_regs_pkg::ADDR_SCR)
			scr <= wdata; // scratch, no side effects
	end

	////////////////// line status ///////////////////
	// errors latch once per entry, when it reaches the head
	assign head_new = !rx_empty && !head_checked;

	always_ff @(posedge clk) begin
		if (rst) begin
			oe           <= 1'b0;
			pe           <= 1'b0;
			fe           <= 1'b0;
			head_checked <= 1'b0;
		end else begin
			if (lsr_rd) begin // read clears, a new error in the same cycle wins
				oe <= 1'b0;
				pe <= 1'b0;
				fe <= 1'b0;
			end
			if (rx_push && rx_full)
				oe <= 1'b1; // fifo drops the char
			if (head_new && rx_head[uart_line_pkg::RX_PE_BIT])
				pe <= 1'b1;
			if (head_new && rx_head[uart_line_pkg::RX_FE_BIT])
				fe <= 1'b1;
			if (rx_pop || rx_clr)
				head_checked <= 1'b0; // next head gets a look
			else if (!rx_empty)
				head_checked <= 1'b1;
		end
	end

	always_comb begin
		lsr = '0;
		lsr[uart_regs_pkg::LSR_DR]      = !rx_empty;
		lsr[uart_regs_pkg::LSR_OE]      = oe;
		lsr[uart_regs_pkg::LSR_PE]      = pe;
		lsr[uart_regs_pkg::LSR_FE]      = fe;
		lsr[uart_regs_pkg::LSR_THRE]    = tx_empty;
		lsr[uart_regs_pkg::LSR_TEMT]    = tx_empty && !tx_busy; // shifter idle too
		lsr[uart_regs_pkg::LSR_FIFOERR] = pe | fe;
	end

	////////////////// interrupts ////////////////////
	// THRE latch: set on fifo draining or on enable while empty
	always_ff @(posedge clk) begin
		if (rst) begin
			tx_empty_q <= 1'b1;
			thre_int   <= 1'b0;
		end else begin
			tx_empty_q <= tx_empty;
			if (tx_push || (iir_rd && iir_code == uart_regs_pkg::IIR_THRE))
				thre_int <= 1'b0;
			else if ((tx_empty && !tx_empty_q && ier[uart_regs_pkg::IER_THRE])
			         || (ier_wr && wdata[uart_regs_pkg::IER_THRE] && tx_empty))
				thre_int <= 1'b1;
		end
	end

	always_comb begin // RLS > RDA > THRE
		if (ier[uart_regs_pkg::IER_RLS] && (oe || pe || fe))
			iir_code = uart_regs_pkg::IIR_RLS;
		else if (ier[uart_regs_pkg::IER_RDA] && !rx_empty)
			iir_code = uart_regs_pkg::IIR_RDA;
		else if (ier[uart_regs_pkg::IER_THRE] && thre_int)
			iir_code = uart_regs_pkg::IIR_THRE;
		else
			iir_code = uart_regs_pkg::IIR_NONE;
	end

	assign irq = iir_code != uart_regs_pkg::IIR_NONE;

	////////////////// read mux //////////////////////
	always_comb begin
		case (addr)
			uart_regs_pkg::ADDR_RBR_THR_DLL: rdata = dlab ? dll : rx_head[7:0];
			uart_regs_pkg::ADDR_IER_DLM:     rdata = dlab ? dlm : {5'b0, ier};
			uart_regs_pkg::ADDR_IIR_FCR:     rdata = {uart_regs_pkg::IIR_FIFO_BITS, iir_code};
			uart_regs_pkg::ADDR_LCR:         rdata = lcr;
			uart_regs_pkg::ADDR_LSR:         rdata = lsr;
			uart_regs_pkg::ADDR_SCR:         rdata = scr;
			default:                         rdata = '0; // 4 and 6 unmapped
		endcase
	end

endmodule

//--- src/uart_baud_gen.sv
`timescale 1ns/1ns
//////////////////////////////////////////////////
// 16x tick from a down counter, divisor 0 = stopped
//////////////////////////////////////////////////
module uart_baud_gen (
	input  logic                    clk,
	input  logic                    rst,
	input  uart_line_pkg::divisor_t divisor,
	output logic                    tick
);
	uart_line_pkg::divisor_t cnt;
	uart_line_pkg::divisor_t div_q; // last divisor seen

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt   <= '0;
			div_q <= '0;
			tick  <= 1'b0;
		end else begin
			div_q <= divisor;
			tick  <= 1'b0;
			if (divisor != div_q || divisor == '0) begin
				cnt <= divisor - 1'b1; // reload on change
			end else if (cnt == '0) begin
				cnt  <= divisor - 1'b1;
				tick <= 1'b1;
			end else begin
				cnt <= cnt - 1'b1;
			end
		end
	end

endmodule

//--- src/uart_fifo.sv
`timescale 1ns/1ns
//////////////////////////////////////////////////
// 16 deep first-word-fall-through FIFO
// push when full and pop when empty are ignored
//////////////////////////////////////////////////
module uart_fifo #(
	parameter int WIDTH = 8
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             clr,
	input  logic             push,
	input  logic             pop,
	input  logic [WIDTH-1:0] din,
	output logic [WIDTH-1:0] dout,
	output logic             empty,
	output logic             full
);
	logic [WIDTH-1:0]                  mem [uart_line_pkg::FIFO_DEPTH];
	logic [uart_line_pkg::FIFO_AW-1:0] rd_ptr;
	logic [uart_line_pkg::FIFO_AW-1:0] wr_ptr;
	logic [uart_line_pkg::FIFO_AW:0]   count;
	logic                              do_push;
	logic                              do_pop;

	assign empty   = count == '0;
	assign full    = count == (uart_line_pkg::FIFO_AW + 1)'(uart_line_pkg::FIFO_DEPTH);
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;
	assign dout    = mem[rd_ptr]; // head, valid when !empty

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= din;
	end

	always_ff @(posedge clk) begin
		if (rst || clr) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1; // wraps at depth
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: ;
			endcase
		end
	end

endmodule

//--- src/uart_tx.sv
`timescale 1ns/1ns
//////////////////////////////////////////////////
// serialiser: start, 5..8 data LSB first, parity, 1 stop
// frame begins on a tick, so start latency varies
//////////////////////////////////////////////////
module uart_tx (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 tick,
	input  logic [1:0]           wls,
	input  logic                 pen,
	input  logic                 eps,
	input  logic                 empty,
	input  uart_line_pkg::data_t din,
	output logic                 pop,
	output logic                 sout,
	output logic                 tx_busy
);
	typedef enum logic [2:0] {IDLE, START, DATA, PARITY, STOP} state_t;

	state_t                   state;
	uart_line_pkg::tick_cnt_t tick_cnt;
	uart_line_pkg::bit_cnt_t  bit_cnt;
	uart_line_pkg::data_t     shreg; // unsent bits, next at bit 0
	logic                     par;   // running parity
	logic                     bit_end;
	logic                     last_bit;
	logic                     send_data;

	assign pop       = state == IDLE && !empty && tick;
	assign tx_busy   = state != IDLE;
	assign bit_end   = tick && tick_cnt == uart_line_pkg::tick_cnt_t'(uart_line_pkg::OVERSAMPLE - 1);
	assign last_bit  = bit_cnt == uart_line_pkg::bit_cnt_t'(4 + wls);
	assign send_data = bit_end && (state == START || (state == DATA && !last_bit));

	always_ff @(posedge clk) begin
		if (pop) begin
			shreg <= din;
			par   <= ~eps; // odd parity starts at 1
		end else if (send_data) begin
			shreg <= shreg >> 1;
			par   <= par ^ shreg[0];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= IDLE;
			sout     <= 1'b1; // line idles high
			tick_cnt <= '0;
			bit_cnt  <= '0;
		end else if (pop) begin
			state    <= START;
			sout     <= 1'b0;
			tick_cnt <= '0;
		end else if (tick && state != IDLE) begin
			tick_cnt <= tick_cnt + 1'b1; // wraps to 0 at bit end
			if (bit_end) begin
				case (state)
					START: begin
						state   <= DATA;
						sout    <= shreg[0];
						bit_cnt <= '0;
					end
					DATA: begin
						if (!last_bit) begin
							sout    <= shreg[0];
							bit_cnt <= bit_cnt + 1'b1;
						end else if (pen) begin
							state <= PARITY;
							sout  <= par;
						end else begin
							state <= STOP;
							sout  <= 1'b1;
						end
					end
					PARITY: begin
						state <= STOP;
						sout  <= 1'b1;
					end
					default: state <= IDLE; // end of stop bit
				endcase
			end
		end
	end

endmodule

//--- src/uart_rx.sv
`timescale 1ns/1ns
//////////////////////////////////////////////////
// deserialiser, samples at tick phase 7 of each bit
// pushes at the stop bit sample, errors ride in the entry
//////////////////////////////////////////////////
module uart_rx (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     tick,
	input  logic [1:0]               wls,
	input  logic                     pen,
	input  logic                     eps,
	input  logic                     sin,
	output logic                     push,
	output uart_line_pkg::rx_entry_t entry
);
	typedef enum logic [2:0] {IDLE, START, DATA, PARITY, STOP} state_t;

	state_t                   state;
	logic                     sin_m; // synchroniser
	logic                     sin_s;
	uart_line_pkg::tick_cnt_t tick_cnt;
	uart_line_pkg::bit_cnt_t  bit_cnt;
	uart_line_pkg::data_t     shreg;
	logic                     par;
	logic                     pe_q;
	logic                     fe_q;
	logic                     sample;
	logic                     last_bit;

	// start bit sampled at mid phase, later bits one bit time apart
	always_comb begin
		if (state == START)
			sample = tick && tick_cnt == uart_line_pkg::tick_cnt_t'(uart_line_pkg::MID_SAMPLE);
		else
			sample = tick && tick_cnt == uart_line_pkg::tick_cnt_t'(uart_line_pkg::OVERSAMPLE - 1);
	end

	assign last_bit = bit_cnt == uart_line_pkg::bit_cnt_t'(4 + wls);
	assign entry    = {fe_q, pe_q, shreg};

	always_ff @(posedge clk) begin
		if (rst) begin
			sin_m    <= 1'b1;
			sin_s    <= 1'b1;
			state    <= IDLE;
			tick_cnt <= '0;
			bit_cnt  <= '0;
			push     <= 1'b0;
		end else begin
			sin_m <= sin;
			sin_s <= sin_m;
			push  <= 1'b0;
			if (tick)
				tick_cnt <= sample ? '0 : tick_cnt + 1'b1;
			case (state)
				IDLE: begin
					if (tick && !sin_s) begin // falling edge seen
						state    <= START;
						tick_cnt <= '0;
					end
				end
				START: begin
					if (sample) begin
						state   <= sin_s ? IDLE : DATA; // glitch, back to idle
						bit_cnt <= '0;
					end
				end
				DATA: begin
					if (sample) begin
						bit_cnt <= bit_cnt + 1'b1;
						if (last_bit)
							state <= pen ? PARITY : STOP;
					end
				end
				PARITY: begin
					if (sample)
						state <= STOP;
				end
				default: begin
					if (sample) begin
						state <= IDLE;
						push  <= 1'b1;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (sample) begin
			case (state)
				START: begin
					shreg <= '0; // unused upper bits stay zero
					par   <= ~eps;
					pe_q  <= 1'b0;
				end
				DATA: begin
					shreg[bit_cnt] <= sin_s;
					par            <= par ^ sin_s;
				end
				PARITY:  pe_q <= par ^ sin_s; // 1 = mismatch
				STOP:    fe_q <= !sin_s;      // low stop bit
				default: ;
			endcase
		end
	end

endmodule

//--- src/uart_top.sv
`timescale 1ns/1ns
//////////////////////////////////////////////////
// single clock 16550-style UART, no modem pins
//////////////////////////////////////////////////
module uart_top (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     cs,
	input  logic                     wr,
	input  uart_regs_pkg::reg_addr_t addr,
	input  uart_line_pkg::data_t     wdata,
	output uart_line_pkg::data_t     rdata,
	input  logic                     sin,
	output logic                     sout,
	output logic                     irq
);
	logic                     tx_push;
	logic                     rx_pop;
	logic                     tx_clr;
	logic                     rx_clr;
	uart_line_pkg::divisor_t  divisor;
	logic [1:0]               wls;
	logic                     pen;
	logic                     eps;
	logic                     tick;
	uart_line_pkg::data_t     tx_head;
	logic                     tx_pop;
	logic                     tx_empty;
	logic                     tx_busy;
	logic                     rx_push;
	uart_line_pkg::rx_entry_t rx_entry;
	uart_line_pkg::rx_entry_t rx_head;
	logic                     rx_empty;
	logic                     rx_full;

	uart_regs u_regs (
		.clk(clk), .rst(rst), .cs(cs), .wr(wr), .addr(addr), .wdata(wdata),
		.tx_empty(tx_empty), .tx_busy(tx_busy), .rx_empty(rx_empty),
		.rx_full(rx_full), .rx_push(rx_push), .rx_head(rx_head),
		.rdata(rdata), .irq(irq), .tx_push(tx_push), .rx_pop(rx_pop),
		.tx_clr(tx_clr), .rx_clr(rx_clr), .divisor(divisor),
		.wls(wls), .pen(pen), .eps(eps)
	);

	uart_baud_gen u_baud (.clk(clk), .rst(rst), .divisor(divisor), .tick(tick));

	uart_fifo #(.WIDTH(8)) u_tx_fifo (
		.clk(clk), .rst(rst), .clr(tx_clr), .push(tx_push), .pop(tx_pop),
		.din(wdata), .dout(tx_head), .empty(tx_empty), .full()
	);

	uart_fifo #(.WIDTH(uart_line_pkg::RX_ENTRY_W)) u_rx_fifo (
		.clk(clk), .rst(rst), .clr(rx_clr), .push(rx_push), .pop(rx_pop),
		.din(rx_entry), .dout(rx_head), .empty(rx_empty), .full(rx_full)
	);

	uart_tx u_tx (
		.clk(clk), .rst(rst), .tick(tick), .wls(wls), .pen(pen), .eps(eps),
		.empty(tx_empty), .din(tx_head), .pop(tx_pop), .sout(sout), .tx_busy(tx_busy)
	);

	uart_rx u_rx (
		.clk(clk), .rst(rst), .tick(tick), .wls(wls), .pen(pen), .eps(eps),
		.sin(sin), .push(rx_push), .entry(rx_entry)
	);

endmodule

//--- verification/uart_sva.sv
`timescale 1ns/1ns
//////////////////////////////////////////////////
// register block checks, bound into every uart_regs
//////////////////////////////////////////////////
module uart_sva (
	input logic                      clk,
	input logic                      rst,
	input logic [2:0]                ier,
	input logic                      oe,
	input logic                      pe,
	input logic                      fe,
	input logic                      thre_int,
	input logic                      tx_empty,
	input logic                      tx_push,
	input logic                      rx_empty,
	input logic                      rx_push,
	input logic                      rx_pop,
	input logic                      rx_clr,
	input logic                      rx_full,
	input logic                      irq
);

	// dropped char leaves the fill level at full
	a_full_push: assert property (@(posedge clk) disable iff (rst)
		rx_push && rx_full && !rx_pop && !rx_clr |=> rx_full)
		else $error("push into the full rx fifo changed its fill level");

	// any enabled source raises irq, whatever the priority
	a_irq_source: assert property (@(posedge clk) disable iff (rst)
		irq == ((ier[uart_regs_pkg::IER_RLS] && (oe || pe || fe))
		        || (ier[uart_regs_pkg::IER_RDA] && !rx_empty)
		        || (ier[uart_regs_pkg::IER_THRE] && thre_int)))
		else $error("irq disagrees with the enabled interrupt sources");

	a_push_lands: assert property (@(posedge clk) disable iff (rst)
		tx_push |=> !tx_empty) // thr write sits in the tx fifo next cycle
		else $error("THR write did not reach the tx fifo");

endmodule

bind uart_regs uart_sva u_sva (
	.clk(clk),
	.rst(rst),
	.ier(ier),
	.oe(oe),
	.pe(pe),
	.fe(fe),
	.thre_int(thre_int),
	.tx_empty(tx_empty),
	.tx_push(tx_push),
	.rx_empty(rx_empty),
	.rx_push(rx_push),
	.rx_pop(rx_pop),
	.rx_clr(rx_clr),
	.rx_full(rx_full),
	.irq(irq)
);

//--- verification/uart_tb.sv
`timescale 1ns/1ns
//////////////////////////////////////////////////
// directed tests on uart_top, every frame at divisor 1
// sin comes from sout (loopback) or from a bit driver
//////////////////////////////////////////////////
module uart_tb;

	localparam int BIT_CYCLES  = 16;   // divisor 1, one tick per clock
	localparam int FRAMES      = 60;   // upper bound over all tests
	localparam int POLL_LIMIT  = 400;  // status reads before giving up
	localparam int IRQ_LIMIT   = 4000; // cycles, covers 17 back to back frames
	localparam int WATCHDOG_NS = (FRAMES * 160 + 5000) * 10;

	logic                     clk = 1'b0;
	logic                     rst;
	logic                     cs;
	logic                     wr;
	uart_regs_pkg::reg_addr_t addr;
	uart_line_pkg::data_t     wdata;
	uart_line_pkg::data_t     rdata;
	logic                     sin;
	logic                     sout;
	logic                     irq;
	logic                     loop_sel; // 1 = sout fed back to sin
	logic                     drv_bit;  // line level from send_frame
	logic [31:0]              lfsr;
	int                       errors;
	int                       checks;

	assign sin = loop_sel ? sout : drv_bit;

	uart_top DUT (
		.clk(clk), .rst(rst), .cs(cs), .wr(wr), .addr(addr), .wdata(wdata),
		.rdata(rdata), .sin(sin), .sout(sout), .irq(irq)
	);

	always #5 clk = ~clk; // 10 ns period

	initial begin // watchdog
		#(WATCHDOG_NS);
		$display("watchdog expired at %0t, the tests did not finish", $time);
		$display("TEST FAILED");
		$finish;
	end

	////////////////// helpers ///////////////////////
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // x^32+x^22+x^2+x+1
	endfunction

	task automatic rand_byte(output uart_line_pkg::data_t b);
		for (int i = 0; i < 8; i++) begin
			lfsr = lfsr_step(lfsr); // one step per bit
			b    = {b[6:0], lfsr[0]};
		end
	endtask

	task automatic check_data(input uart_line_pkg::data_t got, input uart_line_pkg::data_t exp,
	                          input string msg);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s, got %02h expected %02h", $time, msg, got, exp);
		end
	endtask

	task automatic check_irq(input logic got, input logic exp, input string msg);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s, got %b expected %b", $time, msg, got, exp);
		end
	endtask

	// all bus tasks start and end 1 ns after a rising edge
	task automatic bus_write(input uart_regs_pkg::reg_addr_t a, input uart_line_pkg::data_t d);
		cs    = 1'b1;
		wr    = 1'b1;
		addr  = a;
		wdata = d;
		@(posedge clk);
		#1;
		cs = 1'b0;
		wr = 1'b0;
	endtask

	task automatic bus_read(input uart_regs_pkg::reg_addr_t a, output uart_line_pkg::data_t d);
		cs   = 1'b1;
		wr   = 1'b0;
		addr = a;
		@(negedge clk);
		d = rdata; // combinational, settled mid cycle
		@(posedge clk);
		#1;
		cs = 1'b0;
	endtask

	task automatic read_expect(input uart_regs_pkg::reg_addr_t a, input uart_line_pkg::data_t exp,
	                           input string msg);
		uart_line_pkg::data_t got;
		bus_read(a, got);
		check_data(got, exp, msg);
	endtask

	// divisor 1 then the given line format
	task automatic program_line(input uart_line_pkg::data_t lcr);
		bus_write(uart_regs_pkg::ADDR_LCR, 8'h80); // DLAB on
		bus_write(uart_regs_pkg::ADDR_RBR_THR_DLL, 8'h01);
		bus_write(uart_regs_pkg::ADDR_IER_DLM, 8'h00);
		bus_write(uart_regs_pkg::ADDR_LCR, lcr);
	endtask

	task automatic wait_data(output uart_line_pkg::data_t lsr);
		int n;
		n   = 0;
		lsr = '0;
		while (!lsr[uart_regs_pkg::LSR_DR] && n < POLL_LIMIT) begin
			bus_read(uart_regs_pkg::ADDR_LSR, lsr);
			n++;
		end
		if (!lsr[uart_regs_pkg::LSR_DR]) begin
			errors++;
			$display("no character received after %0d status reads at %0t", n, $time);
		end
	endtask

	task automatic wait_tx_idle();
		uart_line_pkg::data_t lsr;
		int n;
		n   = 0;
		lsr = '0;
		while (!lsr[uart_regs_pkg::LSR_TEMT] && n < POLL_LIMIT) begin
			bus_read(uart_regs_pkg::ADDR_LSR, lsr);
			n++;
		end
		if (!lsr[uart_regs_pkg::LSR_TEMT]) begin
			errors++;
			$display("transmitter still busy after %0d status reads at %0t", n, $time);
		end
	endtask

	task automatic wait_irq(input string what);
		int n;
		n = 0;
		while (irq !== 1'b1 && n < IRQ_LIMIT) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (irq !== 1'b1) begin
			errors++;
			$display("interrupt for %s never came, gave up at %0t", what, $time);
		end
	endtask

	// start, 8 data LSB first, parity, stop, then one idle bit
	task automatic send_frame(input uart_line_pkg::data_t d, input logic par, input logic stop);
		logic [11:0] bits;
		bits = {1'b1, stop, par, d, 1'b0};
		for (int i = 0; i < 12; i++) begin
			drv_bit = bits[i];
			repeat (BIT_CYCLES) @(posedge clk);
			#1;
		end
	endtask

	////////////////// tests /////////////////////////
	task automatic test_reset();
		check_irq(irq, 1'b0, "irq after reset");
		check_irq(sout, 1'b1, "sout idle level after reset");
		read_expect(uart_regs_pkg::ADDR_LSR, 8'h60, "LSR after reset");
		read_expect(uart_regs_pkg::ADDR_IIR_FCR, 8'hc1, "IIR after reset");
	endtask

	task automatic test_registers();
		bus_write(uart_regs_pkg::ADDR_SCR, 8'h5a);
		read_expect(uart_regs_pkg::ADDR_SCR, 8'h5a, "SCR readback");
		bus_write(uart_regs_pkg::ADDR_LCR, 8'h1b);
		read_expect(uart_regs_pkg::ADDR_LCR, 8'h1b, "LCR readback");
		bus_write(uart_regs_pkg::ADDR_LCR, 8'h83); // DLAB set
		bus_write(uart_regs_pkg::ADDR_RBR_THR_DLL, 8'h34);
		bus_write(uart_regs_pkg::ADDR_IER_DLM, 8'h12);
		read_expect(uart_regs_pkg::ADDR_RBR_THR_DLL, 8'h34, "DLL readback");
		read_expect(uart_regs_pkg::ADDR_IER_DLM, 8'h12, "DLM readback");
		bus_write(uart_regs_pkg::ADDR_LCR, 8'h03);
		bus_write(uart_regs_pkg::ADDR_IER_DLM, 8'h05); // RDA and RLS, nothing pending
		read_expect(uart_regs_pkg::ADDR_IER_DLM, 8'h05, "IER readback, DLAB clear");
		bus_write(uart_regs_pkg::ADDR_IER_DLM, 8'h00);
	endtask

	task automatic test_loopback(input uart_line_pkg::data_t lcr, input uart_line_pkg::data_t mask,
	                             input string msg);
		uart_line_pkg::data_t exp [$];
		uart_line_pkg::data_t b;
		uart_line_pkg::data_t got;
		uart_line_pkg::data_t lsr;
		loop_sel = 1'b1;
		program_line(lcr);
		for (int i = 0; i < 16; i++) begin
			rand_byte(b);
			exp.push_back(b & mask); // upper bits come back zero
			bus_write(uart_regs_pkg::ADDR_RBR_THR_DLL, b);
		end
		for (int i = 0; i < 16; i++) begin
			wait_data(lsr);
			check_data(lsr & 8'h0e, 8'h00, "LSR error bits in loopback");
			bus_read(uart_regs_pkg::ADDR_RBR_THR_DLL, got);
			check_data(got, exp.pop_front(), msg);
		end
		wait_tx_idle();
	endtask

	task automatic test_overrun();
		uart_line_pkg::data_t exp [$];
		uart_line_pkg::data_t b;
		uart_line_pkg::data_t got;
		uart_line_pkg::data_t lsr;
		loop_sel = 1'b1;
		program_line(8'h03);
		bus_write(uart_regs_pkg::ADDR_IER_DLM, 8'h04); // RLS only
		for (int i = 0; i < 17; i++) begin
			rand_byte(b);
			exp.push_back(b);
			bus_write(uart_regs_pkg::ADDR_RBR_THR_DLL, b);
		end
		wait_irq("overrun");
		bus_read(uart_regs_pkg::ADDR_LSR, lsr);
		check_data(lsr & 8'h0f, 8'h03, "LSR with overrun");
		bus_read(uart_regs_pkg::ADDR_LSR, lsr);
		check_data(lsr & 8'h0f, 8'h01, "LSR after clearing read");
		check_irq(irq, 1'b0, "irq after overrun cleared");
		for (int i = 0; i < 16; i++) begin // 17th char was dropped
			bus_read(uart_regs_pkg::ADDR_RBR_THR_DLL, got);
			check_data(got, exp.pop_front(), "character kept on overrun");
		end
		bus_read(uart_regs_pkg::ADDR_LSR, lsr);
		check_data(lsr & 8'h01, 8'h00, "DR after draining the rx fifo");
		bus_write(uart_regs_pkg::ADDR_IER_DLM, 8'h00);
		wait_tx_idle();
	endtask

	task automatic test_line_errors();
		uart_line_pkg::data_t a;
		uart_line_pkg::data_t b;
		uart_line_pkg::data_t lsr;
		drv_bit  = 1'b1;
		loop_sel = 1'b0;
		program_line(8'h1b); // 8 bits, even parity
		bus_write(uart_regs_pkg::ADDR_IER_DLM, 8'h04);
		rand_byte(a);
		send_frame(a, ~(^a), 1'b1); // parity bit flipped
		wait_irq("parity error");
		read_expect(uart_regs_pkg::ADDR_IIR_FCR, 8'hc6, "IIR on parity error");
		check_irq(irq, 1'b1, "irq on parity error");
		bus_read(uart_regs_pkg::ADDR_LSR, lsr);
		check_data(lsr & 8'h8f, 8'h85, "LSR on parity error");
		check_irq(irq, 1'b0, "irq after LSR read");
		read_expect(uart_regs_pkg::ADDR_RBR_THR_DLL, a, "data of parity error frame");
		rand_byte(b);
		send_frame(b, ^b, 1'b0); // stop bit low
		wait_irq("framing error");
		read_expect(uart_regs_pkg::ADDR_IIR_FCR, 8'hc6, "IIR on framing error");
		check_irq(irq, 1'b1, "irq on framing error");
		bus_read(uart_regs_pkg::ADDR_LSR, lsr);
		check_data(lsr & 8'h8f, 8'h89, "LSR on framing error");
		check_irq(irq, 1'b0, "irq after LSR read");
		read_expect(uart_regs_pkg::ADDR_RBR_THR_DLL, b, "data of framing error frame");
		bus_write(uart_regs_pkg::ADDR_IER_DLM, 8'h00);
	endtask

	task automatic test_interrupts();
		uart_line_pkg::data_t c;
		bus_write(uart_regs_pkg::ADDR_IER_DLM, 8'h01); // RDA
		rand_byte(c);
		send_frame(c, ^c, 1'b1);
		wait_irq("received data");
		read_expect(uart_regs_pkg::ADDR_IIR_FCR, 8'hc4, "IIR with data available");
		read_expect(uart_regs_pkg::ADDR_RBR_THR_DLL, c, "received byte");
		read_expect(uart_regs_pkg::ADDR_IIR_FCR, 8'hc1, "IIR after RBR read");
		check_irq(irq, 1'b0, "irq after RBR read");
		bus_write(uart_regs_pkg::ADDR_IER_DLM, 8'h02); // THRE, tx fifo empty
		check_irq(irq, 1'b1, "irq on THRE enable");
		read_expect(uart_regs_pkg::ADDR_IIR_FCR, 8'hc2, "IIR with THRE pending");
		read_expect(uart_regs_pkg::ADDR_IIR_FCR, 8'hc1, "IIR after THRE reported");
		check_irq(irq, 1'b0, "irq after IIR read");
	endtask

	////////////////// main //////////////////////////
	initial begin
		cs       = 1'b0;
		wr       = 1'b0;
		addr     = '0;
		wdata    = '0;
		loop_sel = 1'b1;
		drv_bit  = 1'b1; // idle line
		rst      = 1'b1;
		lfsr     = 32'h70a1_df14;
		errors   = 0;
		checks   = 0;
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;
		test_reset();
		test_registers();
		test_loopback(8'h03, 8'hff, "8N1 loopback byte");
		test_loopback(8'h09, 8'h3f, "6-bit odd parity loopback byte");
		test_overrun();
		test_line_errors();
		test_interrupts();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- files.f
src/uart_line_pkg.sv
src/uart_regs_pkg.sv
src/uart_regs.sv
src/uart_baud_gen.sv
src/uart_fifo.sv
src/uart_tx.sv
src/uart_rx.sv
src/uart_top.sv
verification/uart_sva.sv
verification/uart_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Verilator build and run of uart_tb, pass only when the pass line is printed
cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal --top-module uart_tb -Mdir obj_dir -f files.f &&
./obj_dir/Vuart_tb | tee /dev/stderr | grep -qx "TEST OK" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
